// ==== Bender.yml ====
package:
  name: insn_decoder

sources:
  - design/decode_pkg.sv
  - design/special_decoder.sv
  - design/opcode_decoder.sv
  - design/branch_target_unit.sv
  - design/insn_decoder.sv
  - target: test
    files:
      - test/insn_decoder_sva.sv
      - test/tb_insn_decoder.sv

// ==== design/branch_target_unit.sv ====
// Combinational and the jump region is taken from the PC of the branch itself
module branch_target_unit (
	input  logic [decode_pkg::word_w-1:0] pc,
	input  decode_pkg::insn_fields_t      fields,
	input  decode_pkg::target_sel_e       sel,
	output logic [decode_pkg::word_w-1:0] target
);

	logic [decode_pkg::word_w-1:0] offset;

	assign offset = {{14{fields.imm16[15]}}, fields.imm16, 2'b00};

	always_comb begin
		case (sel)
			decode_pkg::tgt_pc_rel: target = pc + decode_pkg::pc_step + offset;
			decode_pkg::tgt_region: target = {pc[31:28], fields.index26, 2'b00};
			default:                target = '0;
		endcase
	end

endmodule

// ==== design/decode_pkg.sv ====
// Integer subset of MIPS32 only and no encodings for COP0, BREAK or SYSCALL
package decode_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int op_w       = 6;
	localparam int func_w     = 6;
	localparam int imm_w      = 16;
	localparam int index_w    = 26;

	// Bit positions of the upper fields in the instruction word
	localparam int op_pos = 26;
	localparam int rs_pos = 21;
	localparam int rt_pos = 16;
	localparam int rd_pos = 11;
	localparam int sa_pos = 6;

	localparam logic [reg_addr_w-1:0] reg_zero = 5'd0;
	localparam logic [reg_addr_w-1:0] reg_ra   = 5'd31;
	localparam logic [word_w-1:0]     pc_step  = 32'd4;

	typedef struct packed {
		logic [op_w-1:0]       op;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] sa;
		logic [func_w-1:0]     func;
		logic [imm_w-1:0]      imm16;
		logic [index_w-1:0]    index26;
	} insn_fields_t;

	typedef enum logic [op_w-1:0] {
		op_special = 6'h00, op_regimm = 6'h01, op_j    = 6'h02, op_jal   = 6'h03,
		op_beq     = 6'h04, op_bne    = 6'h05, op_blez = 6'h06, op_bgtz  = 6'h07,
		op_addi    = 6'h08, op_addiu  = 6'h09, op_slti = 6'h0a, op_sltiu = 6'h0b,
		op_andi    = 6'h0c, op_ori    = 6'h0d, op_xori = 6'h0e, op_lui   = 6'h0f,
		op_lb      = 6'h20, op_lh     = 6'h21, op_lw   = 6'h23, op_lbu   = 6'h24,
		op_lhu     = 6'h25, op_sb     = 6'h28, op_sh   = 6'h29, op_sw    = 6'h2b
	} opcode_e;

	typedef enum logic [func_w-1:0] {
		fun_sll  = 6'h00, fun_srl   = 6'h02, fun_sra  = 6'h03, fun_sllv  = 6'h04,
		fun_srlv = 6'h06, fun_srav  = 6'h07, fun_jr   = 6'h08, fun_jalr  = 6'h09,
		fun_mfhi = 6'h10, fun_mthi  = 6'h11, fun_mflo = 6'h12, fun_mtlo  = 6'h13,
		fun_mult = 6'h18, fun_multu = 6'h19, fun_div  = 6'h1a, fun_divu  = 6'h1b,
		fun_add  = 6'h20, fun_addu  = 6'h21, fun_sub  = 6'h22, fun_subu  = 6'h23,
		fun_and  = 6'h24, fun_or    = 6'h25, fun_xor  = 6'h26, fun_nor   = 6'h27,
		fun_slt  = 6'h2a, fun_sltu  = 6'h2b
	} func_e;

	// REGIMM selects the branch in the rt field
	typedef enum logic [reg_addr_w-1:0] {
		rt_bltz = 5'h00, rt_bgez = 5'h01, rt_bltzal = 5'h10, rt_bgezal = 5'h11
	} regimm_e;

	typedef enum logic [5:0] {
		insn_nop,
		insn_add, insn_addu, insn_sub, insn_subu, insn_slt, insn_sltu,
		insn_and, insn_or, insn_xor, insn_nor,
		insn_sll, insn_srl, insn_sra, insn_sllv, insn_srlv, insn_srav,
		insn_mult, insn_multu, insn_div, insn_divu,
		insn_jr, insn_jalr, insn_mfhi, insn_mflo, insn_mthi, insn_mtlo,
		insn_addi, insn_addiu, insn_slti, insn_sltiu,
		insn_andi, insn_ori, insn_xori, insn_lui,
		insn_beq, insn_bne, insn_bgtz, insn_blez,
		insn_bgez, insn_bltz, insn_bgezal, insn_bltzal,
		insn_j, insn_jal,
		insn_lb, insn_lbu, insn_lh, insn_lhu, insn_lw,
		insn_sb, insn_sh, insn_sw,
		insn_undefined = 6'h39
	} insn_op_e;

	// Loads and stores are ALU class
	typedef enum logic [2:0] {
		unit_alu  = 3'd0,
		unit_mult = 3'd1,
		unit_div  = 3'd2
	} unit_e;

	typedef enum logic [1:0] {
		br_none, br_direct, br_return, br_indirect
	} branch_kind_e;

	typedef enum logic [1:0] {
		tgt_none, tgt_pc_rel, tgt_region
	} target_sel_e;

	typedef enum logic [4:0] {
		exc_ri   = 5'h0a,
		exc_none = 5'h10
	} exc_code_e;

	typedef struct packed {
		logic [reg_addr_w-1:0] dst;
		logic [reg_addr_w-1:0] src0;
		logic [reg_addr_w-1:0] src1;
		logic [word_w-1:0]     imm;
		unit_e                 unit;
		insn_op_e              op;
	} decode_info_t;

	typedef struct packed {
		logic src0_rd;
		logic src1_rd;
		logic dst_wr;
		logic imm_use;
		logic hilo_use;
	} operand_use_t;

	typedef struct packed {
		logic              en;
		branch_kind_e      kind;
		logic [word_w-1:0] target;
	} branch_hint_t;

	typedef struct packed {
		decode_info_t info;
		operand_use_t use_flags;
		branch_kind_e kind;
		logic         en;
		target_sel_e  sel;
	} decode_result_t;

	localparam decode_info_t nop_info = '{
		dst:  reg_zero,
		src0: reg_zero,
		src1: reg_zero,
		imm:  '0,
		unit: unit_alu,
		op:   insn_nop
	};

	localparam branch_hint_t nop_branch = '{en: 1'b0, kind: br_none, target: '0};

endpackage

// ==== design/insn_decoder.sv ====
// One cycle of latency with valid sampled as a level and no back-pressure
module insn_decoder (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [decode_pkg::word_w-1:0] pc,
	input  logic [decode_pkg::word_w-1:0] insn,
	input  logic                          valid,
	output logic                          id_valid,
	output decode_pkg::decode_info_t      id_info,
	output decode_pkg::operand_use_t      id_use,
	output decode_pkg::branch_hint_t      id_branch,
	output decode_pkg::exc_code_e         id_exc
);

	decode_pkg::insn_fields_t      fields;
	decode_pkg::decode_result_t    result;
	decode_pkg::exc_code_e         exc;
	logic [decode_pkg::word_w-1:0] target;

	// The immediate and index fields overlap the register fields
	always_comb begin
		fields.op      = insn[decode_pkg::op_pos +: decode_pkg::op_w];
		fields.rs      = insn[decode_pkg::rs_pos +: decode_pkg::reg_addr_w];
		fields.rt      = insn[decode_pkg::rt_pos +: decode_pkg::reg_addr_w];
		fields.rd      = insn[decode_pkg::rd_pos +: decode_pkg::reg_addr_w];
		fields.sa      = insn[decode_pkg::sa_pos +: decode_pkg::reg_addr_w];
		fields.func    = insn[decode_pkg::func_w-1:0];
		fields.imm16   = insn[decode_pkg::imm_w-1:0];
		fields.index26 = insn[decode_pkg::index_w-1:0];
	end

	opcode_decoder i_opcode_decoder (
		.fields(fields),
		.result(result)
	);

	branch_target_unit i_branch_target_unit (
		.pc    (pc),
		.fields(fields),
		.sel   (result.sel),
		.target(target)
	);

	always_comb begin
		if (result.info.op == decode_pkg::insn_undefined) begin
			exc = decode_pkg::exc_ri;
		end else begin
			exc = decode_pkg::exc_none;
		end
	end

	// Decode pipeline register and a bubble loads the NOP record
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid  <= 1'b0;
			id_info   <= decode_pkg::nop_info;
			id_use    <= '0;
			id_branch <= decode_pkg::nop_branch;
			id_exc    <= decode_pkg::exc_none;
		end else if (valid) begin
			id_valid  <= 1'b1;
			id_info   <= result.info;
			id_use    <= result.use_flags;
			id_branch <= '{en: result.en, kind: result.kind, target: target};
			id_exc    <= exc;
		end else begin
			id_valid  <= 1'b0;
			id_info   <= decode_pkg::nop_info;
			id_use    <= '0;
			id_branch <= decode_pkg::nop_branch;
			id_exc    <= decode_pkg::exc_none;
		end
	end

endmodule

// ==== design/opcode_decoder.sv ====
// Combinational primary decode and the jump immediate holds only the in-region offset
module opcode_decoder (
	input  decode_pkg::insn_fields_t   fields,
	output decode_pkg::decode_result_t result
);

	decode_pkg::decode_result_t    special_result;
	decode_pkg::insn_op_e          op;
	logic                          legal;
	logic                          link;
	logic [decode_pkg::word_w-1:0] imm_sext;
	logic [decode_pkg::word_w-1:0] imm_zext;
	logic [decode_pkg::word_w-1:0] imm_branch;
	logic [decode_pkg::word_w-1:0] imm_region;

	special_decoder i_special_decoder (
		.fields(fields),
		.result(special_result)
	);

	assign imm_sext   = {{16{fields.imm16[15]}}, fields.imm16};
	assign imm_zext   = {16'h0, fields.imm16};
	assign imm_branch = {{14{fields.imm16[15]}}, fields.imm16, 2'b00};
	assign imm_region = {4'h0, fields.index26, 2'b00};

	// Linking REGIMM branches write r31
	assign link = (fields.rt == decode_pkg::rt_bgezal) || (fields.rt == decode_pkg::rt_bltzal);

	always_comb begin
		case (fields.op)
			decode_pkg::op_special: op = special_result.info.op;
			decode_pkg::op_regimm: begin
				case (fields.rt)
					decode_pkg::rt_bltz:   op = decode_pkg::insn_bltz;
					decode_pkg::rt_bgez:   op = decode_pkg::insn_bgez;
					decode_pkg::rt_bltzal: op = decode_pkg::insn_bltzal;
					decode_pkg::rt_bgezal: op = decode_pkg::insn_bgezal;
					default:               op = decode_pkg::insn_undefined;
				endcase
			end
			decode_pkg::op_j:     op = decode_pkg::insn_j;
			decode_pkg::op_jal:   op = decode_pkg::insn_jal;
			decode_pkg::op_beq:   op = decode_pkg::insn_beq;
			decode_pkg::op_bne:   op = decode_pkg::insn_bne;
			decode_pkg::op_blez:  op = decode_pkg::insn_blez;
			decode_pkg::op_bgtz:  op = decode_pkg::insn_bgtz;
			decode_pkg::op_addi:  op = decode_pkg::insn_addi;
			decode_pkg::op_addiu: op = decode_pkg::insn_addiu;
			decode_pkg::op_slti:  op = decode_pkg::insn_slti;
			decode_pkg::op_sltiu: op = decode_pkg::insn_sltiu;
			decode_pkg::op_andi:  op = decode_pkg::insn_andi;
			decode_pkg::op_ori:   op = decode_pkg::insn_ori;
			decode_pkg::op_xori:  op = decode_pkg::insn_xori;
			decode_pkg::op_lui:   op = decode_pkg::insn_lui;
			decode_pkg::op_lb:    op = decode_pkg::insn_lb;
			decode_pkg::op_lbu:   op = decode_pkg::insn_lbu;
			decode_pkg::op_lh:    op = decode_pkg::insn_lh;
			decode_pkg::op_lhu:   op = decode_pkg::insn_lhu;
			decode_pkg::op_lw:    op = decode_pkg::insn_lw;
			decode_pkg::op_sb:    op = decode_pkg::insn_sb;
			decode_pkg::op_sh:    op = decode_pkg::insn_sh;
			decode_pkg::op_sw:    op = decode_pkg::insn_sw;
			default:              op = decode_pkg::insn_undefined;
		endcase
	end

	always_comb begin
		result = '0;
		legal  = 1'b1;
		case (fields.op)
			decode_pkg::op_special: begin
				result = special_result;
			end
			decode_pkg::op_addi, decode_pkg::op_addiu, decode_pkg::op_slti,
			decode_pkg::op_sltiu, decode_pkg::op_lb, decode_pkg::op_lbu,
			decode_pkg::op_lh, decode_pkg::op_lhu, decode_pkg::op_lw: begin
				result.info.dst  = fields.rt;
				result.info.src0 = fields.rs;
				result.info.imm  = imm_sext;
				result.use_flags = '{src0_rd: 1'b1, dst_wr: 1'b1, imm_use: 1'b1, default: 1'b0};
			end
			decode_pkg::op_andi, decode_pkg::op_ori, decode_pkg::op_xori: begin
				result.info.dst  = fields.rt;
				result.info.src0 = fields.rs;
				result.info.imm  = imm_zext;
				result.use_flags = '{src0_rd: 1'b1, dst_wr: 1'b1, imm_use: 1'b1, default: 1'b0};
			end
			decode_pkg::op_lui: begin
				legal            = (fields.rs == decode_pkg::reg_zero);
				result.info.dst  = fields.rt;
				result.info.imm  = {fields.imm16, 16'h0};
				result.use_flags = '{dst_wr: 1'b1, imm_use: 1'b1, default: 1'b0};
			end
			decode_pkg::op_sb, decode_pkg::op_sh, decode_pkg::op_sw: begin
				result.info.src0 = fields.rs;
				result.info.src1 = fields.rt;
				result.info.imm  = imm_sext;
				result.use_flags = '{src0_rd: 1'b1, src1_rd: 1'b1, imm_use: 1'b1, default: 1'b0};
			end
			decode_pkg::op_beq, decode_pkg::op_bne: begin
				result.info.src0 = fields.rs;
				result.info.src1 = fields.rt;
				result.info.imm  = imm_branch;
				result.use_flags = '{src0_rd: 1'b1, src1_rd: 1'b1, imm_use: 1'b1, default: 1'b0};
				result.sel       = decode_pkg::tgt_pc_rel;
			end
			decode_pkg::op_bgtz, decode_pkg::op_blez: begin
				legal            = (fields.rt == decode_pkg::reg_zero);
				result.info.src0 = fields.rs;
				result.info.imm  = imm_branch;
				result.use_flags = '{src0_rd: 1'b1, imm_use: 1'b1, default: 1'b0};
				result.sel       = decode_pkg::tgt_pc_rel;
			end
			decode_pkg::op_regimm: begin
				result.info.dst  = link ? decode_pkg::reg_ra : decode_pkg::reg_zero;
				result.info.src0 = fields.rs;
				result.info.imm  = imm_branch;
				result.use_flags = '{src0_rd: 1'b1, dst_wr: link, imm_use: 1'b1, default: 1'b0};
				result.sel       = decode_pkg::tgt_pc_rel;
			end
			decode_pkg::op_j, decode_pkg::op_jal: begin
				if (fields.op == decode_pkg::op_jal) begin
					result.info.dst = decode_pkg::reg_ra;
				end
				result.info.imm  = imm_region;
				result.use_flags = '{dst_wr: (fields.op == decode_pkg::op_jal), imm_use: 1'b1,
					default: 1'b0};
				result.sel       = decode_pkg::tgt_region;
			end
			default: begin
				legal = 1'b0;
			end
		endcase

		// Anything with a computed target is a direct branch
		if (result.sel != decode_pkg::tgt_none) begin
			result.en   = 1'b1;
			result.kind = decode_pkg::br_direct;
		end

		result.info.op = op;
		if (!legal || op == decode_pkg::insn_undefined) begin
			result         = '0;
			result.info.op = decode_pkg::insn_undefined;
		end
	end

endmodule

// ==== design/special_decoder.sv ====
// Combinational decode of the SPECIAL function field and BREAK or SYSCALL fall out as undefined
module special_decoder (
	input  decode_pkg::insn_fields_t   fields,
	output decode_pkg::decode_result_t result
);

	decode_pkg::insn_op_e op;
	logic                 legal;

	always_comb begin
		case (fields.func)
			decode_pkg::fun_add:   op = decode_pkg::insn_add;
			decode_pkg::fun_addu:  op = decode_pkg::insn_addu;
			decode_pkg::fun_sub:   op = decode_pkg::insn_sub;
			decode_pkg::fun_subu:  op = decode_pkg::insn_subu;
			decode_pkg::fun_slt:   op = decode_pkg::insn_slt;
			decode_pkg::fun_sltu:  op = decode_pkg::insn_sltu;
			decode_pkg::fun_and:   op = decode_pkg::insn_and;
			decode_pkg::fun_or:    op = decode_pkg::insn_or;
			decode_pkg::fun_xor:   op = decode_pkg::insn_xor;
			decode_pkg::fun_nor:   op = decode_pkg::insn_nor;
			decode_pkg::fun_sll:   op = decode_pkg::insn_sll;
			decode_pkg::fun_srl:   op = decode_pkg::insn_srl;
			decode_pkg::fun_sra:   op = decode_pkg::insn_sra;
			decode_pkg::fun_sllv:  op = decode_pkg::insn_sllv;
			decode_pkg::fun_srlv:  op = decode_pkg::insn_srlv;
			decode_pkg::fun_srav:  op = decode_pkg::insn_srav;
			decode_pkg::fun_mult:  op = decode_pkg::insn_mult;
			decode_pkg::fun_multu: op = decode_pkg::insn_multu;
			decode_pkg::fun_div:   op = decode_pkg::insn_div;
			decode_pkg::fun_divu:  op = decode_pkg::insn_divu;
			decode_pkg::fun_jr:    op = decode_pkg::insn_jr;
			decode_pkg::fun_jalr:  op = decode_pkg::insn_jalr;
			decode_pkg::fun_mfhi:  op = decode_pkg::insn_mfhi;
			decode_pkg::fun_mflo:  op = decode_pkg::insn_mflo;
			decode_pkg::fun_mthi:  op = decode_pkg::insn_mthi;
			decode_pkg::fun_mtlo:  op = decode_pkg::insn_mtlo;
			default:               op = decode_pkg::insn_undefined;
		endcase
	end

	always_comb begin
		result = '0;
		legal  = 1'b0;
		case (fields.func)
			decode_pkg::fun_add, decode_pkg::fun_addu, decode_pkg::fun_sub,
			decode_pkg::fun_subu, decode_pkg::fun_slt, decode_pkg::fun_sltu,
			decode_pkg::fun_and, decode_pkg::fun_or, decode_pkg::fun_xor,
			decode_pkg::fun_nor, decode_pkg::fun_sllv, decode_pkg::fun_srlv,
			decode_pkg::fun_srav: begin
				legal            = (fields.sa == '0);
				result.info.dst  = fields.rd;
				result.info.src0 = fields.rs;
				result.info.src1 = fields.rt;
				result.use_flags = '{src0_rd: 1'b1, src1_rd: 1'b1, dst_wr: 1'b1, default: 1'b0};
			end
			// Shift amount travels as the immediate
			decode_pkg::fun_sll, decode_pkg::fun_srl, decode_pkg::fun_sra: begin
				legal            = (fields.rs == '0);
				result.info.dst  = fields.rd;
				result.info.src0 = fields.rt;
				result.info.imm  = {27'h0, fields.sa};
				result.use_flags = '{src0_rd: 1'b1, dst_wr: 1'b1, imm_use: 1'b1, default: 1'b0};
			end
			decode_pkg::fun_mult, decode_pkg::fun_multu,
			decode_pkg::fun_div, decode_pkg::fun_divu: begin
				legal            = (fields.sa == '0) && (fields.rd == '0);
				result.info.src0 = fields.rs;
				result.info.src1 = fields.rt;
				result.use_flags = '{src0_rd: 1'b1, src1_rd: 1'b1, hilo_use: 1'b1, default: 1'b0};
				if (op == decode_pkg::insn_div || op == decode_pkg::insn_divu) begin
					result.info.unit = decode_pkg::unit_div;
				end else begin
					result.info.unit = decode_pkg::unit_mult;
				end
			end
			decode_pkg::fun_jr, decode_pkg::fun_mthi, decode_pkg::fun_mtlo: begin
				legal            = (fields.sa == '0) && (fields.rt == '0) && (fields.rd == '0);
				result.info.src0 = fields.rs;
				result.use_flags = '{src0_rd: 1'b1, hilo_use: (op != decode_pkg::insn_jr),
					default: 1'b0};
				if (op == decode_pkg::insn_jr) begin
					result.en   = 1'b1;
					result.kind = decode_pkg::br_return;
				end
			end
			// Target comes from a register so no target select
			decode_pkg::fun_jalr: begin
				legal            = (fields.sa == '0) && (fields.rt == '0);
				result.info.dst  = fields.rd;
				result.info.src0 = fields.rs;
				result.use_flags = '{src0_rd: 1'b1, dst_wr: 1'b1, default: 1'b0};
				result.en        = 1'b1;
				result.kind      = decode_pkg::br_indirect;
			end
			decode_pkg::fun_mfhi, decode_pkg::fun_mflo: begin
				legal            = (fields.sa == '0) && (fields.rt == '0) && (fields.rs == '0);
				result.info.dst  = fields.rd;
				result.use_flags = '{dst_wr: 1'b1, hilo_use: 1'b1, default: 1'b0};
			end
			default: begin
				legal = 1'b0;
			end
		endcase

		result.info.op = op;
		if (!legal) begin
			result         = '0;
			result.info.op = decode_pkg::insn_undefined;
		end
	end

endmodule

// ==== list.f ====
design/decode_pkg.sv
design/special_decoder.sv
design/opcode_decoder.sv
design/branch_target_unit.sv
design/insn_decoder.sv
test/insn_decoder_sva.sv
test/tb_insn_decoder.sv

// ==== test/insn_decoder_sva.sv ====
// Reference decode rules checked one cycle after each sampled input and counted through fail_count
module insn_decoder_sva (
	input logic                          clk,
	input logic                          arst_n,
	input logic [decode_pkg::word_w-1:0] pc,
	input logic [decode_pkg::word_w-1:0] insn,
	input logic                          valid,
	input logic                          id_valid,
	input decode_pkg::decode_info_t      id_info,
	input decode_pkg::operand_use_t      id_use,
	input decode_pkg::branch_hint_t      id_branch,
	input decode_pkg::exc_code_e         id_exc
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		decode_pkg::decode_info_t info;
		decode_pkg::operand_use_t use_flags;
		decode_pkg::branch_hint_t branch;
		decode_pkg::exc_code_e    exc;
	} expect_t;

	int unsigned fail_count = 0;
	logic        prev_valid;
	logic [31:0] prev_insn;
	logic [31:0] prev_pc;
	expect_t     want;

	// SPECIAL function codes of the MIPS32 integer set
	function automatic decode_pkg::insn_op_e special_op(input logic [5:0] fn);
		decode_pkg::insn_op_e o;
		case (fn)
			6'h00: o = decode_pkg::insn_sll;
			6'h02: o = decode_pkg::insn_srl;
			6'h03: o = decode_pkg::insn_sra;
			6'h04: o = decode_pkg::insn_sllv;
			6'h06: o = decode_pkg::insn_srlv;
			6'h07: o = decode_pkg::insn_srav;
			6'h08: o = decode_pkg::insn_jr;
			6'h09: o = decode_pkg::insn_jalr;
			6'h10: o = decode_pkg::insn_mfhi;
			6'h11: o = decode_pkg::insn_mthi;
			6'h12: o = decode_pkg::insn_mflo;
			6'h13: o = decode_pkg::insn_mtlo;
			6'h18: o = decode_pkg::insn_mult;
			6'h19: o = decode_pkg::insn_multu;
			6'h1a: o = decode_pkg::insn_div;
			6'h1b: o = decode_pkg::insn_divu;
			6'h20: o = decode_pkg::insn_add;
			6'h21: o = decode_pkg::insn_addu;
			6'h22: o = decode_pkg::insn_sub;
			6'h23: o = decode_pkg::insn_subu;
			6'h24: o = decode_pkg::insn_and;
			6'h25: o = decode_pkg::insn_or;
			6'h26: o = decode_pkg::insn_xor;
			6'h27: o = decode_pkg::insn_nor;
			6'h2a: o = decode_pkg::insn_slt;
			6'h2b: o = decode_pkg::insn_sltu;
			default: o = decode_pkg::insn_undefined;
		endcase
		return o;
	endfunction

	// Primary opcodes with the REGIMM branch picked from rt
	function automatic decode_pkg::insn_op_e primary_op(input logic [5:0] opc,
		input logic [4:0] rt);
		decode_pkg::insn_op_e o;
		case (opc)
			6'h01: begin
				case (rt)
					5'h00: o = decode_pkg::insn_bltz;
					5'h01: o = decode_pkg::insn_bgez;
					5'h10: o = decode_pkg::insn_bltzal;
					5'h11: o = decode_pkg::insn_bgezal;
					default: o = decode_pkg::insn_undefined;
				endcase
			end
			6'h02: o = decode_pkg::insn_j;
			6'h03: o = decode_pkg::insn_jal;
			6'h04: o = decode_pkg::insn_beq;
			6'h05: o = decode_pkg::insn_bne;
			6'h06: o = decode_pkg::insn_blez;
			6'h07: o = decode_pkg::insn_bgtz;
			6'h08: o = decode_pkg::insn_addi;
			6'h09: o = decode_pkg::insn_addiu;
			6'h0a: o = decode_pkg::insn_slti;
			6'h0b: o = decode_pkg::insn_sltiu;
			6'h0c: o = decode_pkg::insn_andi;
			6'h0d: o = decode_pkg::insn_ori;
			6'h0e: o = decode_pkg::insn_xori;
			6'h0f: o = decode_pkg::insn_lui;
			6'h20: o = decode_pkg::insn_lb;
			6'h21: o = decode_pkg::insn_lh;
			6'h23: o = decode_pkg::insn_lw;
			6'h24: o = decode_pkg::insn_lbu;
			6'h25: o = decode_pkg::insn_lhu;
			6'h28: o = decode_pkg::insn_sb;
			6'h29: o = decode_pkg::insn_sh;
			6'h2b: o = decode_pkg::insn_sw;
			default: o = decode_pkg::insn_undefined;
		endcase
		return o;
	endfunction

	// Use flags in the order src0, src1, dst, imm, hilo
	function automatic expect_t ref_decode(input logic [31:0] w, input logic [31:0] p);
		expect_t              e;
		decode_pkg::insn_op_e o;
		logic [4:0]           rs;
		logic [4:0]           rt;
		logic [4:0]           rd;
		logic [4:0]           sa;
		logic [31:0]          sext;
		logic [31:0]          boff;
		logic                 ok;
		logic                 rel;
		rs   = w[25:21];
		rt   = w[20:16];
		rd   = w[15:11];
		sa   = w[10:6];
		sext = {{16{w[15]}}, w[15:0]};
		boff = {sext[29:0], 2'b00};
		e    = '0;
		ok   = 1'b1;
		rel  = 1'b0;
		o    = (w[31:26] == 6'h00) ? special_op(w[5:0]) : primary_op(w[31:26], rt);
		case (o)
			decode_pkg::insn_add, decode_pkg::insn_addu, decode_pkg::insn_sub,
			decode_pkg::insn_subu, decode_pkg::insn_slt, decode_pkg::insn_sltu,
			decode_pkg::insn_and, decode_pkg::insn_or, decode_pkg::insn_xor,
			decode_pkg::insn_nor, decode_pkg::insn_sllv, decode_pkg::insn_srlv,
			decode_pkg::insn_srav: begin
				ok          = (sa == 5'd0);
				e.info.dst  = rd;
				e.info.src0 = rs;
				e.info.src1 = rt;
				e.use_flags = 5'b11100;
			end
			decode_pkg::insn_sll, decode_pkg::insn_srl, decode_pkg::insn_sra: begin
				ok          = (rs == 5'd0);
				e.info.dst  = rd;
				e.info.src0 = rt;
				e.info.imm  = {27'd0, sa};
				e.use_flags = 5'b10110;
			end
			decode_pkg::insn_mult, decode_pkg::insn_multu,
			decode_pkg::insn_div, decode_pkg::insn_divu: begin
				ok          = (sa == 5'd0) && (rd == 5'd0);
				e.info.src0 = rs;
				e.info.src1 = rt;
				e.use_flags = 5'b11001;
				e.info.unit = (o == decode_pkg::insn_div || o == decode_pkg::insn_divu) ?
					decode_pkg::unit_div : decode_pkg::unit_mult;
			end
			decode_pkg::insn_jr, decode_pkg::insn_mthi, decode_pkg::insn_mtlo: begin
				ok          = (sa == 5'd0) && (rt == 5'd0) && (rd == 5'd0);
				e.info.src0 = rs;
				e.use_flags = (o == decode_pkg::insn_jr) ? 5'b10000 : 5'b10001;
				if (o == decode_pkg::insn_jr) begin
					e.branch.en   = 1'b1;
					e.branch.kind = decode_pkg::br_return;
				end
			end
			decode_pkg::insn_jalr: begin
				ok            = (sa == 5'd0) && (rt == 5'd0);
				e.info.dst    = rd;
				e.info.src0   = rs;
				e.use_flags   = 5'b10100;
				e.branch.en   = 1'b1;
				e.branch.kind = decode_pkg::br_indirect;
			end
			decode_pkg::insn_mfhi, decode_pkg::insn_mflo: begin
				ok          = (sa == 5'd0) && (rt == 5'd0) && (rs == 5'd0);
				e.info.dst  = rd;
				e.use_flags = 5'b00101;
			end
			decode_pkg::insn_addi, decode_pkg::insn_addiu, decode_pkg::insn_slti,
			decode_pkg::insn_sltiu, decode_pkg::insn_lb, decode_pkg::insn_lbu,
			decode_pkg::insn_lh, decode_pkg::insn_lhu, decode_pkg::insn_lw: begin
				e.info.dst  = rt;
				e.info.src0 = rs;
				e.info.imm  = sext;
				e.use_flags = 5'b10110;
			end
			decode_pkg::insn_andi, decode_pkg::insn_ori, decode_pkg::insn_xori: begin
				e.info.dst  = rt;
				e.info.src0 = rs;
				e.info.imm  = {16'h0, w[15:0]};
				e.use_flags = 5'b10110;
			end
			decode_pkg::insn_lui: begin
				ok          = (rs == 5'd0);
				e.info.dst  = rt;
				e.info.imm  = {w[15:0], 16'h0};
				e.use_flags = 5'b00110;
			end
			decode_pkg::insn_sb, decode_pkg::insn_sh, decode_pkg::insn_sw: begin
				e.info.src0 = rs;
				e.info.src1 = rt;
				e.info.imm  = sext;
				e.use_flags = 5'b11010;
			end
			decode_pkg::insn_beq, decode_pkg::insn_bne: begin
				e.info.src0 = rs;
				e.info.src1 = rt;
				e.info.imm  = boff;
				e.use_flags = 5'b11010;
				rel         = 1'b1;
			end
			decode_pkg::insn_bgtz, decode_pkg::insn_blez: begin
				ok          = (rt == 5'd0);
				e.info.src0 = rs;
				e.info.imm  = boff;
				e.use_flags = 5'b10010;
				rel         = 1'b1;
			end
			decode_pkg::insn_bgez, decode_pkg::insn_bltz,
			decode_pkg::insn_bgezal, decode_pkg::insn_bltzal: begin
				e.info.src0 = rs;
				e.info.imm  = boff;
				e.use_flags = 5'b10010;
				rel         = 1'b1;
				// Linking forms write r31
				if (o == decode_pkg::insn_bgezal || o == decode_pkg::insn_bltzal) begin
					e.info.dst  = 5'd31;
					e.use_flags = 5'b10110;
				end
			end
			decode_pkg::insn_j, decode_pkg::insn_jal: begin
				e.info.dst    = (o == decode_pkg::insn_jal) ? 5'd31 : 5'd0;
				e.info.imm    = {4'h0, w[25:0], 2'b00};
				e.use_flags   = (o == decode_pkg::insn_jal) ? 5'b00110 : 5'b00010;
				e.branch.en   = 1'b1;
				e.branch.kind = decode_pkg::br_direct;
				e.branch.target = {p[31:28], w[25:0], 2'b00};
			end
			default: begin
				ok = 1'b0;
			end
		endcase
		if (rel) begin
			e.branch.en     = 1'b1;
			e.branch.kind   = decode_pkg::br_direct;
			e.branch.target = p + 32'd4 + boff;
		end
		e.info.op = o;
		e.exc     = decode_pkg::exc_none;
		if (!ok) begin
			e         = '0;
			e.info.op = decode_pkg::insn_undefined;
			e.exc     = decode_pkg::exc_ri;
		end
		return e;
	endfunction

	// Inputs as seen at the previous rising edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_valid <= 1'b0;
			prev_insn  <= '0;
			prev_pc    <= '0;
		end else begin
			prev_valid <= valid;
			prev_insn  <= insn;
			prev_pc    <= pc;
		end
	end

	always_comb begin
		want = ref_decode(prev_insn, prev_pc);
	end

	bubble_outputs: assert property (@(posedge clk) disable iff (!arst_n)
		!prev_valid |-> !id_valid && !id_branch.en && id_branch.kind == decode_pkg::br_none
			&& id_branch.target == '0 && id_exc == decode_pkg::exc_none && id_use == '0
			&& id_info == {15'h0, 32'h0, decode_pkg::unit_alu, decode_pkg::insn_nop})
	else begin
		fail_count++;
		$error("error bubble: id_valid %h id_info %h id_use %h id_branch %h id_exc %h",
			$sampled(id_valid), $sampled(id_info), $sampled(id_use),
			$sampled(id_branch), $sampled(id_exc));
	end

	// Every accepted instruction shows up on the next edge
	no_bubble: assert property (@(posedge clk) disable iff (!arst_n) prev_valid |-> id_valid)
	else begin
		fail_count++;
		$error("error id_valid: got %h expected %h", $sampled(id_valid), 1'b1);
	end

	info_match: assert property (@(posedge clk) disable iff (!arst_n)
		prev_valid |-> id_info == want.info)
	else begin
		fail_count++;
		$error("error id_info: insn %h got %h expected %h", $sampled(prev_insn),
			$sampled(id_info), $sampled(want.info));
	end

	use_match: assert property (@(posedge clk) disable iff (!arst_n)
		prev_valid |-> id_use == want.use_flags)
	else begin
		fail_count++;
		$error("error id_use: insn %h got %h expected %h", $sampled(prev_insn),
			$sampled(id_use), $sampled(want.use_flags));
	end

	branch_match: assert property (@(posedge clk) disable iff (!arst_n)
		prev_valid |-> id_branch == want.branch)
	else begin
		fail_count++;
		$error("error id_branch: insn %h got %h expected %h", $sampled(prev_insn),
			$sampled(id_branch), $sampled(want.branch));
	end

	exc_match: assert property (@(posedge clk) disable iff (!arst_n)
		prev_valid |-> id_exc == want.exc)
	else begin
		fail_count++;
		$error("error id_exc: insn %h got %h expected %h", $sampled(prev_insn),
			$sampled(id_exc), $sampled(want.exc));
	end

endmodule

bind insn_decoder insn_decoder_sva i_insn_decoder_sva (.*);

// ==== test/tb_insn_decoder.sv ====
// Results are judged by the bound checker and a batch waits at most 8 cycles for a decoded result
module tb_insn_decoder;
	timeunit 1ns;
	timeprecision 1ps;

	logic                          clk;
	logic                          arst_n;
	logic [decode_pkg::word_w-1:0] pc;
	logic [decode_pkg::word_w-1:0] insn;
	logic                          valid;
	logic                          id_valid;
	decode_pkg::decode_info_t      id_info;
	decode_pkg::operand_use_t      id_use;
	decode_pkg::branch_hint_t      id_branch;
	decode_pkg::exc_code_e         id_exc;

	int unsigned timeouts;
	int unsigned sent;
	int unsigned failures;

	insn_decoder i_insn_decoder (
		.clk      (clk),
		.arst_n   (arst_n),
		.pc       (pc),
		.insn     (insn),
		.valid    (valid),
		.id_valid (id_valid),
		.id_info  (id_info),
		.id_use   (id_use),
		.id_branch(id_branch),
		.id_exc   (id_exc)
	);

	always #20 clk = ~clk;

	// Fields {rs, rt, rd, sa} that meet or break each zero-field rule
	function automatic logic [19:0] reg_pattern(input int k);
		case (k)
			0: return {5'd0, 5'd0, 5'd0, 5'd0};
			1: return {5'd9, 5'd10, 5'd11, 5'd0};
			2: return {5'd0, 5'd10, 5'd11, 5'd5};
			3: return {5'd9, 5'd0, 5'd0, 5'd0};
			4: return {5'd9, 5'd0, 5'd11, 5'd0};
			5: return {5'd0, 5'd0, 5'd11, 5'd0};
			6: return {5'd9, 5'd10, 5'd0, 5'd0};
			default: return {5'd9, 5'd10, 5'd11, 5'd3};
		endcase
	endfunction

	// Fields {rs, rt, imm16} with both offset signs and zero or non-zero rs and rt
	function automatic logic [25:0] imm_pattern(input int k);
		case (k)
			0: return {5'd4, 5'd0, 16'h8004};
			1: return {5'd0, 5'd6, 16'h7ffc};
			2: return {5'd4, 5'd6, 16'h1234};
			default: return {5'd0, 5'd0, 16'hfff0};
		endcase
	endfunction

	task automatic send(input logic [31:0] w);
		@(negedge clk);
		valid = 1'b1;
		insn  = w;
		pc    = sent * 32'h1234_5674;
		sent++;
	endtask

	task automatic finish_batch(input string name);
		int unsigned cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!id_valid && cycles < 8);
		valid = 1'b0;
		if (!id_valid) begin
			timeouts++;
			$display("timeout: the %s batch gave no decoded result within %0d cycles", name,
				cycles);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		clk      = 1'b0;
		arst_n   = 1'b0;
		pc       = '0;
		insn     = '0;
		valid    = 1'b0;
		timeouts = 0;
		sent     = 0;
		void'($urandom(32'h4b48_9d10));
		for (int c = 0; c < 2; c++) begin
			@(posedge clk);
		end
		@(negedge clk);
		arst_n = 1'b1;

		for (int fn = 0; fn < 64; fn++) begin
			for (int k = 0; k < 8; k++) begin
				send({6'h00, reg_pattern(k), 6'(fn)});
			end
		end
		finish_batch("SPECIAL");

		for (int op = 1; op < 64; op++) begin
			for (int k = 0; k < 4; k++) begin
				send({6'(op), imm_pattern(k)});
			end
		end
		finish_batch("opcode");

		for (int rt = 0; rt < 32; rt++) begin
			send({6'h01, 5'd7, 5'(rt), 16'hfff6});
			send({6'h01, 5'd7, 5'(rt), 16'h0040});
		end
		finish_batch("REGIMM");

		// ERET, MFC0, MTC0, SYSCALL and BREAK
		send(32'h4200_0018);
		send(32'h4002_6000);
		send(32'h4082_6000);
		send(32'h0000_000c);
		send(32'h0000_000d);
		finish_batch("dropped");

		for (int n = 0; n < 400; n++) begin
			@(negedge clk);
			rnd   = $urandom();
			valid = rnd[0];
			insn  = $urandom();
			pc    = $urandom();
		end
		send(32'h0000_0000);
		finish_batch("random");

		for (int c = 0; c < 3; c++) begin
			@(negedge clk);
		end
		failures = i_insn_decoder.i_insn_decoder_sva.fail_count;
		$display("closing: %0d failed checks, %0d timeouts, %0d directed instructions",
			failures, timeouts, sent);
		if (failures == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
